//--- logic/cache_decode.sv
`timescale 1ns/1ns

module cache_decode #(
  parameter int num_sets = 4,
  localparam int idx_w = $clog2(num_sets)
) (
  // processor request addresses
  input  logic             s_arvalid,
  input  cache_pkg::addr_t s_araddr,
  input  cache_pkg::addr_t s_awaddr,
  // split request
  output logic             req_read,
  output cache_pkg::addr_t req_addr,
  output logic [idx_w-1:0] req_index,
  output cache_pkg::addr_t req_tag,
  // stored line at req_index
  input  cache_pkg::addr_t line_tag,
  input  logic             line_valid,
  input  logic             line_dirty,
  // lookup result
  output logic             hit,
  output logic             victim_dirty,
  output cache_pkg::addr_t victim_addr
);
  import cache_pkg::*;

  // byte offset inside the word, then the index, then the tag
  localparam int off_w = $clog2(strb_w);
  localparam int tag_lsb = off_w + idx_w;

  // reads and writes never arrive together, so the read address wins
  assign req_read  = s_arvalid;
  assign req_addr  = s_arvalid ? s_araddr : s_awaddr;
  assign req_index = req_addr[off_w +: idx_w];
  assign req_tag   = req_addr >> tag_lsb;

  assign hit = line_valid && (line_tag == req_tag);

  // an invalid line never needs a write-back
  assign victim_dirty = line_valid && line_dirty;

  // stored tag back in place, word aligned
  assign victim_addr = (line_tag << tag_lsb) | (addr_t'(req_index) << off_w);

endmodule

//--- logic/cache_execute.sv
`timescale 1ns/1ns

module cache_execute #(
  parameter int num_sets = 4,
  localparam int idx_w = $clog2(num_sets)
) (
  input  logic             ACLK,
  input  logic             ARESETn,
  // processor request side
  input  logic             s_arvalid,
  input  logic             s_awvalid,
  input  logic             s_wvalid,
  input  cache_pkg::data_t s_wdata,
  input  cache_pkg::strb_t s_wstrb,
  output logic             s_arready,
  output logic             s_awready,
  output logic             s_wready,
  // from decode
  input  logic             req_read,
  input  cache_pkg::addr_t req_addr,
  input  logic [idx_w-1:0] req_index,
  input  cache_pkg::addr_t req_tag,
  input  logic             hit,
  input  logic             victim_dirty,
  input  cache_pkg::addr_t victim_addr,
  input  cache_pkg::data_t line_data,
  // store updates
  output logic             fill_en,
  output logic [idx_w-1:0] fill_index,
  output cache_pkg::addr_t fill_tag,
  output cache_pkg::data_t fill_data,
  output logic             wr_en,
  output logic [idx_w-1:0] wr_index,
  output cache_pkg::data_t wr_data,
  output cache_pkg::strb_t wr_strb,
  // memory manager port
  output logic             m_arvalid,
  input  logic             m_arready,
  output cache_pkg::addr_t m_araddr,
  input  logic             m_rvalid,
  output logic             m_rready,
  input  cache_pkg::data_t m_rdata,
  output logic             m_awvalid,
  input  logic             m_awready,
  output cache_pkg::addr_t m_awaddr,
  output logic             m_wvalid,
  input  logic             m_wready,
  output cache_pkg::data_t m_wdata,
  output cache_pkg::strb_t m_wstrb,
  input  logic             m_bvalid,
  output logic             m_bready,
  // toward result
  output logic             rd_push,
  output cache_pkg::data_t rd_data,
  output logic             wr_push,
  input  logic             pending
);
  import cache_pkg::*;

  exec_state_t      state;
  logic             accept;
  logic             take_read;
  logic             take_write;
  logic             take_req;
  logic             fill_done;
  // request saved across a miss
  logic             sv_read;
  addr_t            sv_addr;
  logic [idx_w-1:0] sv_index;
  addr_t            sv_tag;
  data_t            sv_wdata;
  strb_t            sv_wstrb;

  // one request in flight, and none while a response waits for the processor
  assign accept    = (state == idle) && !pending;
  assign s_arready = accept;
  assign s_awready = accept;
  assign s_wready  = accept;

  assign take_read  = accept && s_arvalid;
  assign take_write = accept && !s_arvalid && s_awvalid && s_wvalid;
  assign take_req   = take_read || take_write;
  assign fill_done  = (state == fill) && m_rvalid;

  assign m_rready = (state == fill);
  assign m_bready = (state == writeback);
  assign m_wstrb  = '1;
  // fill reads the saved request address, also after a write-back
  assign m_araddr = sv_addr;

  assign fill_en    = fill_done;
  assign fill_index = sv_index;
  assign fill_tag   = sv_tag;
  assign fill_data  = m_rdata;

  // hit path serves the live request, fill path serves the saved one
  always_comb begin
    wr_en    = 1'b0;
    wr_index = req_index;
    wr_data  = s_wdata;
    wr_strb  = s_wstrb;
    rd_push  = 1'b0;
    rd_data  = line_data;
    wr_push  = 1'b0;
    if (take_req && hit) begin
      rd_push = take_read;
      wr_push = take_write;
      wr_en   = take_write;
    end else if (fill_done) begin
      wr_index = sv_index;
      wr_data  = sv_wdata;
      wr_strb  = sv_wstrb;
      rd_data  = m_rdata;
      rd_push  = sv_read;
      wr_push  = !sv_read;
      wr_en    = !sv_read;
    end
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state     <= idle;
      m_arvalid <= 1'b0;
      m_awvalid <= 1'b0;
      m_wvalid  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (take_req && !hit) begin
            if (victim_dirty) begin
              state     <= writeback;
              m_awvalid <= 1'b1;
              m_wvalid  <= 1'b1;
            end else begin
              state     <= fill;
              m_arvalid <= 1'b1;
            end
          end
        end
        writeback: begin
          // AW and W complete independently
          if (m_awready) begin
            m_awvalid <= 1'b0;
          end
          if (m_wready) begin
            m_wvalid <= 1'b0;
          end
          if (m_bvalid) begin
            state     <= fill;
            m_arvalid <= 1'b1;
          end
        end
        fill: begin
          if (m_arready) begin
            m_arvalid <= 1'b0;
          end
          if (m_rvalid) begin
            state <= idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (take_req && !hit) begin
      sv_read  <= req_read;
      sv_addr  <= req_addr;
      sv_index <= req_index;
      sv_tag   <= req_tag;
      sv_wdata <= s_wdata;
      sv_wstrb <= s_wstrb;
      m_awaddr <= victim_addr;
      m_wdata  <= line_data;
    end
  end

endmodule

//--- logic/cache_pkg.sv
package cache_pkg;

  // bus widths shared by both AXI4-Lite ports
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // byte address on either port
  typedef logic [addr_w-1:0] addr_t;

  // one data word, which is also one cache block
  typedef logic [data_w-1:0] data_t;

  // one byte-enable per data byte
  typedef logic [strb_w-1:0] strb_t;

  // AXI response code
  typedef logic [1:0] resp_t;

  // the cache never reports an error
  localparam resp_t resp_okay = 2'b00;

  // AXI protection field
  typedef logic [2:0] prot_t;

  // miss/fill controller states
  typedef enum logic [1:0] {
    // accepting requests
    idle,
    // victim write outstanding
    writeback,
    // memory read outstanding
    fill,
    // handing the result over
    respond
  } exec_state_t;

endpackage

//--- logic/cache_result.sv
`timescale 1ns/1ns

module cache_result (
  input  logic             ACLK,
  input  logic             ARESETn,
  // one-cycle pushes from execute
  input  logic             rd_push,
  input  cache_pkg::data_t rd_data,
  input  logic             wr_push,
  // processor response readies
  input  logic             s_rready,
  input  logic             s_bready,
  // held responses
  output logic             s_rvalid,
  output cache_pkg::data_t s_rdata,
  output logic             s_bvalid,
  output logic             pending
);
  import cache_pkg::*;

  // execute stops accepting while anything is held
  assign pending = s_rvalid || s_bvalid;

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      s_rvalid <= 1'b0;
      s_bvalid <= 1'b0;
    end else begin
      if (rd_push) begin
        s_rvalid <= 1'b1;
      end else if (s_rvalid && s_rready) begin
        s_rvalid <= 1'b0;
      end
      if (wr_push) begin
        s_bvalid <= 1'b1;
      end else if (s_bvalid && s_bready) begin
        s_bvalid <= 1'b0;
      end
    end
  end

  // read data stays put until the next push
  always_ff @(posedge ACLK) begin
    if (rd_push) begin
      s_rdata <= rd_data;
    end
  end

endmodule

//--- logic/cache_store.sv
`timescale 1ns/1ns

module cache_store #(
  parameter int num_sets = 4,
  localparam int idx_w = $clog2(num_sets)
) (
  input  logic             ACLK,
  input  logic             ARESETn,
  // lookup port, read without a clock
  input  logic [idx_w-1:0] rd_index,
  output cache_pkg::addr_t line_tag,
  output logic             line_valid,
  output logic             line_dirty,
  output cache_pkg::data_t line_data,
  // whole-line install from memory
  input  logic             fill_en,
  input  logic [idx_w-1:0] fill_index,
  input  cache_pkg::addr_t fill_tag,
  input  cache_pkg::data_t fill_data,
  // byte-strobed write from the processor
  input  logic             wr_en,
  input  logic [idx_w-1:0] wr_index,
  input  cache_pkg::data_t wr_data,
  input  cache_pkg::strb_t wr_strb
);
  import cache_pkg::*;

  addr_t               tag_mem [num_sets];
  data_t               data_mem[num_sets];
  logic [num_sets-1:0] valid_bits;
  logic [num_sets-1:0] dirty_bits;

  assign line_tag   = tag_mem[rd_index];
  assign line_data  = data_mem[rd_index];
  assign line_valid = valid_bits[rd_index];
  assign line_dirty = dirty_bits[rd_index];

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (fill_en) begin
        valid_bits[fill_index] <= 1'b1;
        dirty_bits[fill_index] <= 1'b0;
      end
      // a write in the same cycle lands after the fill, so the line ends up dirty
      if (wr_en) begin
        dirty_bits[wr_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (fill_en) begin
      tag_mem[fill_index]  <= fill_tag;
      data_mem[fill_index] <= fill_data;
    end
    // enabled bytes override the freshly filled word
    if (wr_en) begin
      for (int b = 0; b < strb_w; b++) begin
        if (wr_strb[b]) begin
          data_mem[wr_index][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- logic/cache_top.sv
`timescale 1ns/1ns

module cache_top #(
  parameter int num_sets = 4
) (
  input  logic             ACLK,
  input  logic             ARESETn,
  // processor side, AXI4-Lite subordinate
  input  logic             s_arvalid,
  output logic             s_arready,
  input  cache_pkg::addr_t s_araddr,
  output logic             s_rvalid,
  input  logic             s_rready,
  output cache_pkg::data_t s_rdata,
  output cache_pkg::resp_t s_rresp,
  input  logic             s_awvalid,
  output logic             s_awready,
  input  cache_pkg::addr_t s_awaddr,
  input  logic             s_wvalid,
  output logic             s_wready,
  input  cache_pkg::data_t s_wdata,
  input  cache_pkg::strb_t s_wstrb,
  output logic             s_bvalid,
  input  logic             s_bready,
  output cache_pkg::resp_t s_bresp,
  // memory side, AXI4-Lite manager
  output logic             m_arvalid,
  input  logic             m_arready,
  output cache_pkg::addr_t m_araddr,
  output cache_pkg::prot_t m_arprot,
  input  logic             m_rvalid,
  output logic             m_rready,
  input  cache_pkg::data_t m_rdata,
  output logic             m_awvalid,
  input  logic             m_awready,
  output cache_pkg::addr_t m_awaddr,
  output cache_pkg::prot_t m_awprot,
  output logic             m_wvalid,
  input  logic             m_wready,
  output cache_pkg::data_t m_wdata,
  output cache_pkg::strb_t m_wstrb,
  input  logic             m_bvalid,
  output logic             m_bready
);
  import cache_pkg::*;

  localparam int idx_w = $clog2(num_sets);

  // lookup
  logic             req_read;
  addr_t            req_addr;
  logic [idx_w-1:0] req_index;
  addr_t            req_tag;
  addr_t            line_tag;
  logic             line_valid;
  logic             line_dirty;
  data_t            line_data;
  logic             hit;
  logic             victim_dirty;
  addr_t            victim_addr;
  // store updates
  logic             fill_en;
  logic [idx_w-1:0] fill_index;
  addr_t            fill_tag;
  data_t            fill_data;
  logic             wr_en;
  logic [idx_w-1:0] wr_index;
  data_t            wr_data;
  strb_t            wr_strb;
  // response hand-off
  logic             rd_push;
  data_t            rd_data;
  logic             wr_push;
  logic             pending;

  assign s_rresp  = resp_okay;
  assign s_bresp  = resp_okay;
  assign m_arprot = '0;
  assign m_awprot = '0;

  cache_store #(.num_sets(num_sets)) u_store (
    .ACLK(ACLK), .ARESETn(ARESETn), .rd_index(req_index),
    .line_tag(line_tag), .line_valid(line_valid), .line_dirty(line_dirty),
    .line_data(line_data), .fill_en(fill_en), .fill_index(fill_index),
    .fill_tag(fill_tag), .fill_data(fill_data), .wr_en(wr_en),
    .wr_index(wr_index), .wr_data(wr_data), .wr_strb(wr_strb)
  );

  cache_decode #(.num_sets(num_sets)) u_decode (
    .s_arvalid(s_arvalid), .s_araddr(s_araddr), .s_awaddr(s_awaddr),
    .req_read(req_read), .req_addr(req_addr), .req_index(req_index),
    .req_tag(req_tag), .line_tag(line_tag), .line_valid(line_valid),
    .line_dirty(line_dirty), .hit(hit), .victim_dirty(victim_dirty),
    .victim_addr(victim_addr)
  );

  cache_execute #(.num_sets(num_sets)) u_execute (
    .ACLK(ACLK), .ARESETn(ARESETn), .s_arvalid(s_arvalid), .s_awvalid(s_awvalid),
    .s_wvalid(s_wvalid), .s_wdata(s_wdata), .s_wstrb(s_wstrb),
    .s_arready(s_arready), .s_awready(s_awready), .s_wready(s_wready),
    .req_read(req_read), .req_addr(req_addr), .req_index(req_index),
    .req_tag(req_tag), .hit(hit), .victim_dirty(victim_dirty),
    .victim_addr(victim_addr), .line_data(line_data), .fill_en(fill_en),
    .fill_index(fill_index), .fill_tag(fill_tag), .fill_data(fill_data),
    .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data), .wr_strb(wr_strb),
    .m_arvalid(m_arvalid), .m_arready(m_arready), .m_araddr(m_araddr),
    .m_rvalid(m_rvalid), .m_rready(m_rready), .m_rdata(m_rdata),
    .m_awvalid(m_awvalid), .m_awready(m_awready), .m_awaddr(m_awaddr),
    .m_wvalid(m_wvalid), .m_wready(m_wready), .m_wdata(m_wdata),
    .m_wstrb(m_wstrb), .m_bvalid(m_bvalid), .m_bready(m_bready),
    .rd_push(rd_push), .rd_data(rd_data), .wr_push(wr_push), .pending(pending)
  );

  cache_result u_result (
    .ACLK(ACLK), .ARESETn(ARESETn), .rd_push(rd_push), .rd_data(rd_data),
    .wr_push(wr_push), .s_rready(s_rready), .s_bready(s_bready),
    .s_rvalid(s_rvalid), .s_rdata(s_rdata), .s_bvalid(s_bvalid), .pending(pending)
  );

endmodule

//--- sim/axil_mem_model.sv
`timescale 1ns/1ns

module axil_mem_model #(
  parameter cache_pkg::data_t fill_pattern = 32'h5a3c_96e1,
  parameter logic [31:0]      seed         = 32'hc7f9c5ad
) (
  input  logic             ACLK,
  input  logic             ARESETn,
  // read channels
  input  logic             arvalid,
  output logic             arready,
  input  cache_pkg::addr_t araddr,
  output logic             rvalid,
  input  logic             rready,
  output cache_pkg::data_t rdata,
  // write channels
  input  logic             awvalid,
  output logic             awready,
  input  cache_pkg::addr_t awaddr,
  input  logic             wvalid,
  output logic             wready,
  input  cache_pkg::data_t wdata,
  input  cache_pkg::strb_t wstrb,
  output logic             bvalid,
  input  logic             bready,
  // transfer log for the testbench
  output int               ar_count,
  output int               aw_count,
  output cache_pkg::addr_t last_araddr,
  output cache_pkg::addr_t last_awaddr,
  output cache_pkg::data_t last_wdata
);
  import cache_pkg::*;

  // sparse word store, untouched words read as address xor pattern
  data_t       mem[addr_t];
  logic [31:0] rng = seed;

  function automatic int next_delay();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return int'(rng[31:30]);
  endfunction

  function automatic data_t word_at(addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a ^ fill_pattern;
  endfunction

  initial begin : read_side
    addr_t a;
    arready  = 1'b0;
    rvalid   = 1'b0;
    rdata    = '0;
    ar_count = 0;
    forever begin
      @(posedge ACLK);
      if (ARESETn && arvalid) begin
        repeat (next_delay()) @(posedge ACLK);
        arready <= 1'b1;
        @(posedge ACLK);
        arready <= 1'b0;
        a = araddr & ~addr_t'(3);
        ar_count++;
        last_araddr = araddr;
        repeat (next_delay()) @(posedge ACLK);
        rdata  <= word_at(a);
        rvalid <= 1'b1;
        @(posedge ACLK);
        while (!rready) @(posedge ACLK);
        rvalid <= 1'b0;
      end
    end
  end

  initial begin : write_side
    int    n;
    int    aw_delay;
    int    w_delay;
    logic  got_aw;
    logic  got_w;
    addr_t a;
    data_t d;
    data_t cur;
    strb_t st;
    awready  = 1'b0;
    wready   = 1'b0;
    bvalid   = 1'b0;
    aw_count = 0;
    forever begin
      @(posedge ACLK);
      if (ARESETn && (awvalid || wvalid)) begin
        aw_delay = next_delay();
        w_delay  = next_delay();
        n        = 0;
        got_aw   = 1'b0;
        got_w    = 1'b0;
        // address and data channels complete on their own schedules
        while (!(got_aw && got_w)) begin
          awready <= !got_aw && (n >= aw_delay);
          wready  <= !got_w && (n >= w_delay);
          @(posedge ACLK);
          if (awvalid && awready) begin
            got_aw = 1'b1;
            a      = awaddr & ~addr_t'(3);
            aw_count++;
            last_awaddr = awaddr;
          end
          if (wvalid && wready) begin
            got_w = 1'b1;
            d     = wdata;
            st    = wstrb;
          end
          n++;
        end
        awready <= 1'b0;
        wready  <= 1'b0;
        last_wdata = d;
        cur = word_at(a);
        for (int b = 0; b < strb_w; b++) begin
          if (st[b]) begin
            cur[8*b +: 8] = d[8*b +: 8];
          end
        end
        mem[a] = cur;
        repeat (next_delay()) @(posedge ACLK);
        bvalid <= 1'b1;
        @(posedge ACLK);
        while (!bready) @(posedge ACLK);
        bvalid <= 1'b0;
      end
    end
  end

endmodule

//--- sim/tb_cache_top.sv
`timescale 1ns/1ns

module tb_cache_top;
  import cache_pkg::*;

  localparam int    num_sets     = 4;
  localparam int    clk_period   = 100;
  localparam data_t fill_pattern = 32'h5a3c_96e1;
  localparam int    bp_requests  = 12;
  localparam int    mix_requests = 60;
  localparam int    num_requests = 9 + bp_requests + mix_requests;
  localparam int    limit_cycles = num_requests * 40 + 100;

  logic  ACLK;
  logic  ARESETn;
  logic  s_arvalid, s_arready, s_rvalid, s_rready;
  addr_t s_araddr;
  data_t s_rdata;
  resp_t s_rresp, s_bresp;
  logic  s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  addr_t s_awaddr;
  data_t s_wdata;
  strb_t s_wstrb;
  logic  m_arvalid, m_arready, m_rvalid, m_rready;
  addr_t m_araddr;
  data_t m_rdata;
  prot_t m_arprot, m_awprot;
  logic  m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
  addr_t m_awaddr;
  data_t m_wdata;
  strb_t m_wstrb;
  int    ar_count, aw_count;
  addr_t last_araddr, last_awaddr;
  data_t last_wdata;

  int          data_errors = 0;
  int          proto_errors = 0;
  logic [31:0] rng_state = 32'hc7f9c5ad;
  data_t       ref_mem[addr_t];
  logic        prev_rvalid, prev_rready, prev_bvalid, prev_bready;
  data_t       prev_rdata;

  cache_top #(.num_sets(num_sets)) UUT (.*);

  axil_mem_model #(.fill_pattern(fill_pattern), .seed(32'hc7f9c5ad)) u_mem (
    .ACLK(ACLK), .ARESETn(ARESETn), .arvalid(m_arvalid), .arready(m_arready),
    .araddr(m_araddr), .rvalid(m_rvalid), .rready(m_rready), .rdata(m_rdata),
    .awvalid(m_awvalid), .awready(m_awready), .awaddr(m_awaddr), .wvalid(m_wvalid),
    .wready(m_wready), .wdata(m_wdata), .wstrb(m_wstrb), .bvalid(m_bvalid),
    .bready(m_bready), .ar_count(ar_count), .aw_count(aw_count),
    .last_araddr(last_araddr), .last_awaddr(last_awaddr), .last_wdata(last_wdata)
  );

  initial begin
    ACLK = 1'b0;
    forever #(clk_period / 2) ACLK = ~ACLK;
  end

  function automatic logic [31:0] random_word();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // expected memory contents, words never written follow the fill pattern
  function automatic data_t ref_word(addr_t a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return a ^ fill_pattern;
  endfunction

  function automatic data_t merge_bytes(data_t old, data_t upd, strb_t st);
    data_t w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (st[b]) begin
        w[8*b +: 8] = upd[8*b +: 8];
      end
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      data_errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_protocol(input string msg);
    proto_errors++;
    $display("%s", msg);
  endtask

  // lat counts edges from the request handshake to the first valid response
  task automatic take_response(input logic is_read, input logic bp, output int lat,
                               output data_t d);
    logic        done;
    logic        seen;
    logic        rdy;
    logic [31:0] rnd;
    done = 1'b0;
    seen = 1'b0;
    lat  = 0;
    d    = '0;
    while (!done) begin
      rnd = random_word();
      rdy = bp ? rnd[31] : 1'b1;
      if (is_read) begin
        s_rready <= rdy;
      end else begin
        s_bready <= rdy;
      end
      @(posedge ACLK);
      if (!seen) begin
        lat++;
      end
      if (is_read ? s_rvalid : s_bvalid) begin
        seen = 1'b1;
        if (is_read ? s_rready : s_bready) begin
          done = 1'b1;
          d    = s_rdata;
        end
      end
    end
    s_rready <= 1'b0;
    s_bready <= 1'b0;
  endtask

  task automatic read_check(input addr_t a, input logic bp, output int lat);
    data_t exp;
    data_t got;
    exp = ref_word(a);
    s_arvalid <= 1'b1;
    s_araddr  <= a;
    @(posedge ACLK);
    while (!s_arready) @(posedge ACLK);
    s_arvalid <= 1'b0;
    take_response(1'b1, bp, lat, got);
    check_value("s_rdata", got, exp);
  endtask

  task automatic write_check(input addr_t a, input data_t d, input strb_t st,
                             input logic bp, output int lat);
    data_t unused;
    s_awvalid <= 1'b1;
    s_awaddr  <= a;
    s_wvalid  <= 1'b1;
    s_wdata   <= d;
    s_wstrb   <= st;
    @(posedge ACLK);
    while (!(s_awready && s_wready)) @(posedge ACLK);
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    take_response(1'b0, bp, lat, unused);
    ref_mem[a] = merge_bytes(ref_word(a), d, st);
  endtask

  // handshake rules, checked with the values the DUT saw at each edge
  always @(posedge ACLK) begin
    if (ARESETn) begin
      if (prev_rvalid && !prev_rready) begin
        assert (s_rvalid && s_rdata === prev_rdata) else
          report_protocol("read response changed before the processor accepted it");
      end
      if (prev_bvalid && !prev_bready) begin
        assert (s_bvalid) else
          report_protocol("write response dropped before the processor accepted it");
      end
      if (s_rvalid || s_bvalid) begin
        assert (!s_arready && !s_awready && !s_wready) else
          report_protocol("request ready high while a response is held");
      end
      assert (!s_rvalid || s_rresp == resp_okay) else begin
        proto_errors++;
        $display("error s_rresp got %h expected %h", s_rresp, resp_okay);
      end
      assert (!s_bvalid || s_bresp == resp_okay) else begin
        proto_errors++;
        $display("error s_bresp got %h expected %h", s_bresp, resp_okay);
      end
      assert (!m_wvalid || m_wstrb == 4'hf) else begin
        proto_errors++;
        $display("error m_wstrb got %h expected %h", m_wstrb, 4'hf);
      end
      assert (!m_arvalid || m_arprot == 3'b000) else begin
        proto_errors++;
        $display("error m_arprot got %h expected %h", m_arprot, 3'b000);
      end
      assert (!m_awvalid || m_awprot == 3'b000) else begin
        proto_errors++;
        $display("error m_awprot got %h expected %h", m_awprot, 3'b000);
      end
      assert (!(s_arvalid && s_awvalid)) else
        report_protocol("read and write presented in the same cycle");
      assert (!(s_arvalid && s_araddr[1:0] != 2'b00)) else
        report_protocol("read address is not word aligned");
      assert (!(s_awvalid && s_awaddr[1:0] != 2'b00)) else
        report_protocol("write address is not word aligned");
    end
    prev_rvalid <= ARESETn && s_rvalid;
    prev_bvalid <= ARESETn && s_bvalid;
    prev_rready <= s_rready;
    prev_bready <= s_bready;
    prev_rdata  <= s_rdata;
  end

  initial begin
    #(limit_cycles * clk_period);
    $display("timeout after %0d cycles, a request never completed", limit_cycles);
    $display("%0d data errors, %0d protocol errors", data_errors, proto_errors);
    $display("Something failed");
    $finish;
  end

  initial begin
    addr_t       a;
    logic [31:0] r;
    int          ar_before;
    int          aw_before;
    int          lat;
    ARESETn   = 1'b0;
    s_arvalid = 1'b0;
    s_araddr  = '0;
    s_rready  = 1'b0;
    s_awvalid = 1'b0;
    s_awaddr  = '0;
    s_wvalid  = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_bready  = 1'b0;
    repeat (4) @(posedge ACLK);
    ARESETn <= 1'b1;
    @(posedge ACLK);
    assert (!s_rvalid && !s_bvalid && !m_arvalid && !m_awvalid && !m_wvalid) else
      report_protocol("a valid output is high after reset");
    assert (s_arready && s_awready && s_wready && !m_rready && !m_bready) else
      report_protocol("ready outputs are wrong after reset");

    // clean read miss goes to memory once
    ar_before = ar_count;
    aw_before = aw_count;
    read_check(32'h0000_1008, 1'b0, lat);
    check_value("memory ar transfers", ar_count - ar_before, 1);
    check_value("m_araddr", last_araddr, 32'h0000_1008);
    check_value("memory aw transfers", aw_count - aw_before, 0);

    // same address again is a hit
    ar_before = ar_count;
    read_check(32'h0000_1008, 1'b0, lat);
    check_value("read hit latency", lat, 1);
    check_value("memory ar transfers", ar_count - ar_before, 0);
    check_value("memory aw transfers", aw_count - aw_before, 0);

    // strobed write hits, each followed by a read back
    write_check(32'h0000_1008, 32'hdead_beef, 4'b0101, 1'b0, lat);
    check_value("write hit latency", lat, 1);
    read_check(32'h0000_1008, 1'b0, lat);
    write_check(32'h0000_1008, 32'h0bad_cafe, 4'b1010, 1'b0, lat);
    read_check(32'h0000_1008, 1'b0, lat);

    // write miss fills index 1, then a different tag evicts the dirty line
    write_check(32'h0000_2004, 32'h1234_5678, 4'b0011, 1'b0, lat);
    ar_before = ar_count;
    aw_before = aw_count;
    read_check(32'h0000_3004, 1'b0, lat);
    check_value("memory aw transfers", aw_count - aw_before, 1);
    check_value("m_awaddr", last_awaddr, 32'h0000_2004);
    check_value("m_wdata", last_wdata, ref_word(32'h0000_2004));
    check_value("memory ar transfers", ar_count - ar_before, 1);
    check_value("m_araddr", last_araddr, 32'h0000_3004);
    read_check(32'h0000_2004, 1'b0, lat);

    // three tags on one index under response back-pressure
    for (int i = 0; i < bp_requests; i++) begin
      a = 32'h0000_5008 | (addr_t'(i % 3) << 4);
      r = random_word();
      if (i % 2 == 0) begin
        write_check(a, random_word(), r[3:0], 1'b1, lat);
      end else begin
        read_check(a, 1'b1, lat);
      end
    end

    // random reads and writes over 16 words, four tags per index
    for (int i = 0; i < mix_requests; i++) begin
      r = random_word();
      a = 32'h0000_4000 | (addr_t'(r[19:16]) << 2);
      if (r[20]) begin
        write_check(a, random_word(), r[27:24], r[21], lat);
      end else begin
        read_check(a, r[21], lat);
      end
    end

    repeat (2) @(posedge ACLK);
    $display("%0d data errors, %0d protocol errors", data_errors, proto_errors);
    if (data_errors == 0 && proto_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
logic/cache_pkg.sv
logic/cache_store.sv
logic/cache_decode.sv
logic/cache_execute.sv
logic/cache_result.sv
logic/cache_top.sv
sim/axil_mem_model.sv
sim/tb_cache_top.sv
